// File: Bender.yml
package:
  name: hidden_mac

sources:
  - files:
      - design/mac_pkg.sv
      - design/mac_cmd_if.sv
      - design/hidden_ram_if.sv
      - design/mac_ctrl.sv
      - design/mac_lanes.sv
      - design/hidden_ram.sv
      - design/hidden_mac_top.sv

  - target: test
    files:
      - tests/tb_hidden_mac.sv

// File: design/hidden_mac_top.sv
// top level of the hidden-layer MAC engine
// control, lanes and hidden memory joined by two interfaces
`timescale 1ns/10ps
`default_nettype none

module hidden_mac_top (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 i_start,
	input  wire                 i_empty,     // source buffer empty
	input  wire                 i_read_done, // source has finished
	input  mac_pkg::lane_t      i_din,
	input  mac_pkg::row_t       i_weights,
	input  mac_pkg::addr_t      i_rd_addr,
	output logic                o_ready,
	output logic                o_next_in,   // end of a 16-row sweep
	output logic                o_all_done,
	output mac_pkg::mac_state_e o_state,
	output mac_pkg::row_t       o_rd_data
);

	mac_cmd_if    u_cmd_if ();
	hidden_ram_if u_ram_if ();

	mac_ctrl u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.i_start     (i_start),
		.i_empty     (i_empty),
		.i_read_done (i_read_done),
		.i_din       (i_din),
		.i_weights   (i_weights),
		.cmd         (u_cmd_if.ctrl),
		.o_ready     (o_ready),
		.o_next_in   (o_next_in),
		.o_all_done  (o_all_done),
		.o_state     (o_state)
	);

	mac_lanes u_lanes (
		.clk   (clk),
		.reset (reset),
		.cmd   (u_cmd_if.lanes),
		.ram   (u_ram_if.lanes)
	);

	hidden_ram u_ram (
		.clk       (clk),
		.reset     (reset),
		.port      (u_ram_if.ram),
		.i_rd_addr (i_rd_addr),
		.o_rd_data (o_rd_data)
	);

endmodule

`default_nettype wire

// File: design/hidden_ram.sv
// result stage: 16-row hidden accumulator memory,
// lane read/write port plus external readback
`timescale 1ns/10ps
`default_nettype none

module hidden_ram (
	input  wire            clk,
	input  wire            reset,
	hidden_ram_if.ram      port,
	input  mac_pkg::addr_t i_rd_addr,
	output mac_pkg::row_t  o_rd_data
);
	import mac_pkg::*;

	row_t mem [DEPTH]; // one row of four lanes per hidden index

	// every run starts from zero sums
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < DEPTH; r++) begin
				mem[r] <= '0;
			end
		end else if (port.wr_en) begin
			mem[port.wr_addr] <= port.wr_data;
		end
	end

	// accumulate side, read and write in the same cycle
	assign port.rd_data = mem[port.rd_addr];

	assign o_rd_data = mem[i_rd_addr]; // readback side

endmodule

`default_nettype wire

// File: design/hidden_ram_if.sv
// accumulator read-modify-write port between lanes and hidden memory
`timescale 1ns/10ps
`default_nettype none

interface hidden_ram_if;
	import mac_pkg::*;

	addr_t rd_addr; // row to accumulate onto
	row_t  rd_data; // combinational from rd_addr
	logic  wr_en;   // write at the rising edge
	addr_t wr_addr;
	row_t  wr_data;

	modport lanes (
		output rd_addr, wr_en, wr_addr, wr_data,
		input  rd_data
	);

	modport ram (
		input  rd_addr, wr_en, wr_addr, wr_data,
		output rd_data
	);

endinterface

`default_nettype wire

// File: design/mac_cmd_if.sv
// sample command from control to the lanes, completion back
`timescale 1ns/10ps
`default_nettype none

interface mac_cmd_if;
	import mac_pkg::*;

	logic  start;   // one-cycle pulse, one command at a time
	lane_t din;     // activation, valid with start
	row_t  weights; // four weights, valid with start
	addr_t addr;    // target row, steady from start to done
	logic  done;    // one-cycle pulse per start

	modport ctrl (
		output start, din, weights, addr,
		input  done
	);

	modport lanes (
		input  start, din, weights, addr,
		output done
	);

endinterface

`default_nettype wire

// File: design/mac_ctrl.sv
// decode stage: run FSM, hidden row address, sample capture,
// ready / next-input / done outputs
`timescale 1ns/10ps
`default_nettype none

module mac_ctrl (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 i_start,
	input  wire                 i_empty,
	input  wire                 i_read_done,
	input  mac_pkg::lane_t      i_din,
	input  mac_pkg::row_t       i_weights,
	mac_cmd_if.ctrl             cmd,
	output logic                o_ready,
	output logic                o_next_in,
	output logic                o_all_done,
	output mac_pkg::mac_state_e o_state
);
	import mac_pkg::*;

	mac_state_e state_q, state_d;
	addr_t      addr_q;
	logic       accept;      // sample taken at this edge
	logic       start_q;
	lane_t      din_q;
	row_t       weights_q;

	assign accept = (state_q == OP_START) && !i_empty;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:     if (i_start) state_d = OP_START;
			OP_START: if (!i_empty) state_d = OP; // empty holds us here
			OP:       if (cmd.done) state_d = OP_DONE; // wait on lanes, not a count
			OP_DONE: begin
				// source finished and drained -> run over
				if (i_read_done && i_empty) state_d = ALL_DONE;
				else state_d = OP_START;
			end
			ALL_DONE: state_d = ALL_DONE;
			default:  state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			addr_q  <= '0;
			start_q <= 1'b0;
		end else begin
			state_q <= state_d;
			start_q <= accept; // one pulse per accepted sample
			if (state_q == IDLE) addr_q <= '0;
			else if (state_q == OP_DONE) addr_q <= addr_q + 1'b1; // 15 wraps to 0
		end
	end

	// sample registers, only meaningful with start_q
	always_ff @(posedge clk) begin
		if (accept) begin
			din_q     <= i_din;
			weights_q <= i_weights;
		end
	end

	assign cmd.start   = start_q;
	assign cmd.din     = din_q;
	assign cmd.weights = weights_q;
	assign cmd.addr    = addr_q; // only moves in OP_DONE, after done

	assign o_ready    = (state_q == OP_START);
	assign o_next_in  = (state_q == OP_DONE) && (addr_q == addr_t'(DEPTH - 1)); // end of sweep
	assign o_all_done = (state_q == ALL_DONE);
	assign o_state    = state_q;

	// acceptance to next ready is four cycles
	a_ready_gap: assert property (@(posedge clk) disable iff (reset)
		o_ready && !i_empty |=> !o_ready [*4])
		else $error("ready returned early after a sample");

	// lane completion only while a sample is in flight
	a_done_in_op: assert property (@(posedge clk) disable iff (reset)
		cmd.done |-> state_q == OP)
		else $error("lane done outside OP");

endmodule

`default_nettype wire

// File: design/mac_lanes.sv
// execute stage: four Q16.16 lanes, multiply then
// read-modify-write accumulate into the hidden memory
`timescale 1ns/10ps
`default_nettype none

module mac_lanes (
	input  wire      clk,
	input  wire      reset,
	mac_cmd_if.lanes cmd,
	hidden_ram_if.lanes ram
);
	import mac_pkg::*;

	logic signed [PROD_W-1:0] full_prod [LANES]; // 64 bit products
	logic signed [PROD_W-1:0] scaled    [LANES]; // back to Q16.16 scale
	row_t prod_d;
	row_t prod_q;     // registered truncated products
	logic prod_valid; // products waiting for the write
	logic done_q;
	row_t sum_row;

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			full_prod[l] = PROD_W'(cmd.din) * PROD_W'(cmd.weights[l]); // signed
			scaled[l]    = full_prod[l] >>> FRAC_BITS;
			prod_d[l]    = lane_t'(scaled[l]); // drop upper bits
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.start) prod_q <= prod_d;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			done_q     <= 1'b0;
		end else begin
			prod_valid <= cmd.start;
			done_q     <= prod_valid; // row written at this same edge
		end
	end

	// stored lanes plus products, 32 bit wrap-around
	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			sum_row[l] = ram.rd_data[l] + prod_q[l];
		end
	end

	assign ram.rd_addr = cmd.addr;
	assign ram.wr_addr = cmd.addr; // same row, addr steady until done
	assign ram.wr_en   = prod_valid;
	assign ram.wr_data = sum_row;
	assign cmd.done    = done_q;

	// one command at a time
	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		cmd.start |-> !prod_valid && !done_q)
		else $error("start while a product is pending");

endmodule

`default_nettype wire

// File: design/mac_pkg.sv
// shared widths, Q16.16 format, lane/row/address types
// and the control state encoding for the hidden-layer MAC
`default_nettype none

package mac_pkg;

	localparam int LANE_W    = 32;         // one Q16.16 lane value
	localparam int LANES     = 4;          // parallel lanes per row
	localparam int DEPTH     = 16;         // hidden rows
	localparam int ADDR_W    = 4;          // row index width
	localparam int FRAC_BITS = 16;         // fraction bits
	localparam int PROD_W    = 2 * LANE_W; // full product before rescale

	// signed fixed point, 16 integer bits and 16 fraction bits
	typedef logic signed [LANE_W-1:0] lane_t;

	// lane 0 sits in the low 32 bits
	typedef lane_t [LANES-1:0] row_t;

	typedef logic [ADDR_W-1:0] addr_t;

	// control flow of one hidden-layer run
	typedef enum logic [2:0] {
		IDLE     = 3'd0, // waiting for start
		OP_START = 3'd1, // ready for a sample
		OP       = 3'd2, // sample in the lanes
		OP_DONE  = 3'd3, // row finished, advance address
		ALL_DONE = 3'd4  // run over, sticky until reset
	} mac_state_e;

endpackage

`default_nettype wire

// File: src.f
design/mac_pkg.sv
design/mac_cmd_if.sv
design/hidden_ram_if.sv
design/mac_ctrl.sv
design/mac_lanes.sv
design/hidden_ram.sv
design/hidden_mac_top.sv
tests/tb_hidden_mac.sv

// File: tests/tb_hidden_mac.sv
// testbench for the hidden-layer MAC engine: stimulus table, Q16.16 reference model,
// typed compare tasks, clock, reset and cycle limit
`timescale 1ns/10ps
`default_nettype none

module tb_hidden_mac;
	import mac_pkg::*;

	typedef struct {
		lane_t din;     // activation
		row_t  w;       // four weights, lane 0 low
		int    hold;    // cycles of i_empty high before the sample
		logic  rd_done; // source finished with this sample
	} entry_t;

	localparam int N_ENTRIES = 18; // one full sweep plus two wrapped rows
	localparam int MAX_HOLD  = 3;
	localparam int LIMIT     = N_ENTRIES * (4 + MAX_HOLD) + 100;

	logic       clk;
	logic       reset;
	logic       i_start;
	logic       i_empty;
	logic       i_read_done;
	lane_t      i_din;
	row_t       i_weights;
	addr_t      i_rd_addr;
	logic       o_ready;
	logic       o_next_in;
	logic       o_all_done;
	mac_state_e o_state;
	row_t       o_rd_data;

	entry_t tbl [N_ENTRIES];
	row_t   model [DEPTH]; // expected hidden sums
	int     seed;
	int     cycle_cnt;

	hidden_mac_top u_dut (
		.clk         (clk),
		.reset       (reset),
		.i_start     (i_start),
		.i_empty     (i_empty),
		.i_read_done (i_read_done),
		.i_din       (i_din),
		.i_weights   (i_weights),
		.i_rd_addr   (i_rd_addr),
		.o_ready     (o_ready),
		.o_next_in   (o_next_in),
		.o_all_done  (o_all_done),
		.o_state     (o_state),
		.o_rd_data   (o_rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) abort_run("run hung, cycle limit reached without finishing");
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_row(input string name, input row_t exp, input row_t act);
		if (act !== exp) abort_run($sformatf("ERROR %s: expected %h actual %h", name, exp, act));
	endtask

	task automatic check_state(input string name, input mac_state_e exp, input mac_state_e act);
		if (act !== exp)
			abort_run($sformatf("ERROR %s: expected %s actual %s", name, exp.name(), act.name()));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) abort_run($sformatf("ERROR %s: expected %b actual %b", name, exp, act));
	endtask

	// Q16.16 product: full signed product, rescale, keep low 32 bits
	function automatic lane_t fixed_product(input lane_t a, input lane_t b);
		longint full;
		full = longint'(a) * longint'(b);
		full = full >>> FRAC_BITS;
		return full[LANE_W-1:0];
	endfunction

	task automatic accumulate(input int row, input lane_t din, input row_t w);
		for (int l = 0; l < LANES; l++) begin
			model[row][l] = model[row][l] + fixed_product(din, w[l]); // 32 bit wrap
		end
	endtask

	task automatic compare_all_rows(input string tag);
		for (int r = 0; r < DEPTH; r++) begin
			@(posedge clk);
			#1 i_rd_addr = addr_t'(r);
			#2 check_row($sformatf("%s readback row %0d", tag, r), model[r], o_rd_data);
		end
	endtask

	task automatic fill_table();
		for (int i = 0; i < N_ENTRIES; i++) begin
			tbl[i].din = lane_t'($random(seed) >>> 12); // roughly +-8.0
			for (int l = 0; l < LANES; l++) tbl[i].w[l] = lane_t'($random(seed) >>> 12);
			tbl[i].hold    = 0;
			tbl[i].rd_done = 1'b0;
		end
		tbl[0].din  = 32'hFFFE_8000; // -1.5
		tbl[0].w[0] = 32'h0002_0000; // 2.0
		tbl[0].w[1] = 32'hFFFC_C000; // -3.25
		tbl[0].w[2] = 32'h0000_8000;
		tbl[0].w[3] = 32'hFFFF_8000;
		tbl[1].din  = 32'h7FFF_0000; // max integer part, products overflow
		tbl[1].w[0] = 32'h0002_0000;
		tbl[1].w[1] = 32'h8000_0000;
		tbl[1].w[2] = 32'h7FFF_FFFF;
		tbl[1].w[3] = 32'hFFFF_FFFF;
		tbl[16].din  = 32'h8000_0000; // most negative, lands on row 0 again
		tbl[16].w[0] = 32'h0001_0000;
		tbl[16].w[1] = 32'hFFFF_0000; // -1.0 times -32768 wraps
		tbl[16].w[2] = 32'h7FFF_0000;
		tbl[16].w[3] = 32'h0000_0003;
		tbl[2].hold  = 1;
		tbl[5].hold  = MAX_HOLD;
		tbl[9].hold  = 2;
		tbl[13].hold = 1;
		tbl[17].hold = 2;
		tbl[N_ENTRIES-1].rd_done = 1'b1; // last sample ends the run
	endtask

	initial begin
		int row;
		seed        = 66;
		cycle_cnt   = 0;
		reset       = 1'b1;
		i_start     = 1'b0;
		i_empty     = 1'b1;
		i_read_done = 1'b0;
		i_din       = '0;
		i_weights   = '0;
		i_rd_addr   = '0;
		for (int r = 0; r < DEPTH; r++) model[r] = '0;
		fill_table();
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		check_bit("reset ready", 1'b0, o_ready);
		check_bit("reset next_in", 1'b0, o_next_in);
		check_bit("reset all_done", 1'b0, o_all_done);
		check_state("reset state", IDLE, o_state);
		compare_all_rows("reset");
		@(posedge clk);
		#1 i_start = 1'b1;
		@(posedge clk);
		#1 i_start = 1'b0;
		check_state("after start", OP_START, o_state);
		for (int i = 0; i < N_ENTRIES; i++) begin
			row       = i % DEPTH;
			i_rd_addr = addr_t'(row); // watch the target row
			while (!o_ready) begin
				@(posedge clk);
				#1;
			end
			repeat (tbl[i].hold) begin
				@(posedge clk);
				#1;
				check_bit($sformatf("sample %0d hold ready", i), 1'b1, o_ready);
				check_state($sformatf("sample %0d hold state", i), OP_START, o_state);
				check_row($sformatf("sample %0d hold row", i), model[row], o_rd_data);
			end
			i_din       = tbl[i].din;
			i_weights   = tbl[i].w;
			i_empty     = 1'b0;
			i_read_done = tbl[i].rd_done;
			accumulate(row, tbl[i].din, tbl[i].w);
			@(posedge clk);
			#1 i_empty = 1'b1; // sample taken here
			repeat (3) @(posedge clk);
			#1;
			check_state($sformatf("sample %0d op_done", i), OP_DONE, o_state);
			check_bit($sformatf("sample %0d next_in", i), logic'(row == DEPTH - 1), o_next_in);
			@(posedge clk);
			#1;
			check_row($sformatf("sample %0d sum", i), model[row], o_rd_data);
			if (tbl[i].rd_done) begin
				check_bit($sformatf("sample %0d all_done", i), 1'b1, o_all_done);
				check_bit($sformatf("sample %0d ready at end", i), 1'b0, o_ready);
			end else begin
				check_bit($sformatf("sample %0d ready", i), 1'b1, o_ready);
				check_bit($sformatf("sample %0d all_done", i), 1'b0, o_all_done);
			end
		end
		@(posedge clk);
		#1 i_start = 1'b1; // must not restart a finished run
		@(posedge clk);
		#1 i_start = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		check_bit("end all_done", 1'b1, o_all_done);
		check_bit("end ready", 1'b0, o_ready);
		check_state("end state", ALL_DONE, o_state);
		compare_all_rows("end");
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
